// ==== hdl/lsu_pkg.sv ====
package lsu_pkg;

	localparam logic [2:0] f3_lb  = 3'b000;
	localparam logic [2:0] f3_lh  = 3'b001;
	localparam logic [2:0] f3_lw  = 3'b010;
	localparam logic [2:0] f3_lbu = 3'b100;
	localparam logic [2:0] f3_lhu = 3'b101;
	localparam logic [2:0] f3_sb  = 3'b000;
	localparam logic [2:0] f3_sh  = 3'b001;
	localparam logic [2:0] f3_sw  = 3'b010;

	localparam logic [1:0] axi_resp_okay = 2'b00;

	localparam logic [31:0] wide_base_reset    = 32'h0f000000;
	localparam logic [31:0] wide_limit_reset   = 32'h0f002000;
	localparam logic [31:0] narrow_base_reset  = 32'h80000000;
	localparam logic [31:0] narrow_limit_reset = 32'hc0000000;

	typedef struct packed {
		logic [2:0]  funct3;
		logic [31:0] src1;
		logic [31:0] src2;
		logic [31:0] imm;
		logic        is_store;
	} lsu_req_t;

	typedef struct packed {
		logic [31:0] load_data;
		logic        was_store;
	} lsu_resp_t;

	// Each window covers base up to, but not including, limit.
	typedef struct packed {
		logic [31:0] wide_base;
		logic [31:0] wide_limit;
		logic [31:0] narrow_base;
		logic [31:0] narrow_limit;
	} lsu_region_t;

	localparam lsu_region_t region_reset = '{
		wide_base:    wide_base_reset,
		wide_limit:   wide_limit_reset,
		narrow_base:  narrow_base_reset,
		narrow_limit: narrow_limit_reset
	};

	typedef struct packed {
		logic [31:0] addr;
		logic [2:0]  size;
	} axi_ar_t;

	typedef struct packed {
		logic [31:0] addr;
		logic [2:0]  size;
	} axi_aw_t;

	typedef struct packed {
		logic [63:0] data;
		logic [7:0]  strb;
	} axi_w_t;

	typedef struct packed {
		logic [63:0] data;
		logic [1:0]  resp;
	} axi_r_t;

endpackage

// ==== hdl/lsu_region_regs.sv ====
`timescale 1ns/1ns

module lsu_region_regs (
	input  logic                 clock,
	input  logic                 rst,
	input  logic                 psel,
	input  logic                 penable,
	input  logic                 pwrite,
	input  logic [3:0]           paddr,
	input  logic [31:0]          pwdata,
	output logic [31:0]          prdata,
	output logic                 pready,
	output logic                 pslverr,
	output lsu_pkg::lsu_region_t region
);

	import lsu_pkg::*;

	logic access;
	logic unmapped;
	logic wr_en;

	// Only word-aligned offsets 0, 4, 8 and 12 hold a register.
	assign unmapped = paddr[1:0] != 2'b00;
	assign access   = psel & penable;
	assign wr_en    = access & pwrite & ~unmapped;

	assign pready  = 1'b1;
	assign pslverr = access & unmapped;

	always_ff @(posedge clock) begin
		if (rst) begin
			region <= region_reset;
		end else if (wr_en) begin
			case (paddr[3:2])
				2'd0: region.wide_base    <= pwdata;
				2'd1: region.wide_limit   <= pwdata;
				2'd2: region.narrow_base  <= pwdata;
				default: region.narrow_limit <= pwdata;
			endcase
		end
	end

	always_comb begin
		if (unmapped) begin
			prdata = '0;
		end else begin
			case (paddr[3:2])
				2'd0: prdata = region.wide_base;
				2'd1: prdata = region.wide_limit;
				2'd2: prdata = region.narrow_base;
				default: prdata = region.narrow_limit;
			endcase
		end
	end

endmodule

// ==== hdl/lsu_load_align.sv ====
`timescale 1ns/1ns

module lsu_load_align (
	input  logic [63:0]          rdata,
	input  logic [31:0]          addr,
	input  logic [2:0]           funct3,
	input  lsu_pkg::lsu_region_t region,
	output logic [31:0]          load_data
);

	import lsu_pkg::*;

	logic        in_wide;
	logic        in_narrow;
	logic [31:0] half;
	logic [31:0] shifted;
	logic [31:0] raw;

	assign in_wide   = (addr >= region.wide_base) && (addr < region.wide_limit);
	assign in_narrow = (addr >= region.narrow_base) && (addr < region.narrow_limit);

	// The upper half is only reachable through the wide window.
	assign half    = (in_wide && addr[2]) ? rdata[63:32] : rdata[31:0];
	assign shifted = half >> {addr[1:0], 3'b000};
	assign raw     = (in_wide || in_narrow) ? shifted : half;

	always_comb begin
		case (funct3)
			f3_lb:   load_data = {{24{raw[7]}}, raw[7:0]};
			f3_lh:   load_data = {{16{raw[15]}}, raw[15:0]};
			f3_lw:   load_data = raw;
			f3_lbu:  load_data = {24'b0, raw[7:0]};
			f3_lhu:  load_data = {16'b0, raw[15:0]};
			default: load_data = '0;
		endcase
	end

endmodule

// ==== hdl/lsu_core.sv ====
`timescale 1ns/1ns

module lsu_core (
	input  logic                 clock,
	input  logic                 rst,
	input  lsu_pkg::lsu_req_t    req,
	input  logic                 req_valid,
	output logic                 req_ready,
	output lsu_pkg::lsu_resp_t   resp,
	output logic                 resp_valid,
	input  lsu_pkg::lsu_region_t region,
	output lsu_pkg::axi_ar_t     ar,
	output logic                 arvalid,
	input  logic                 arready,
	input  lsu_pkg::axi_r_t      r,
	input  logic                 rvalid,
	output logic                 rready,
	output lsu_pkg::axi_aw_t     aw,
	output logic                 awvalid,
	input  logic                 awready,
	output lsu_pkg::axi_w_t      w,
	output logic                 wvalid,
	input  logic                 wready,
	input  logic                 bvalid,
	output logic                 bready
);

	import lsu_pkg::*;

	lsu_req_t    req_q;
	logic        busy;
	logic        accept;
	logic        done;
	logic [31:0] addr;
	logic [2:0]  size;
	logic [3:0]  mask;
	logic [31:0] aligned;

	assign accept    = req_valid & req_ready;
	assign req_ready = ~busy;

	assign addr = req_q.src1 + req_q.imm;
	assign size = {1'b0, req_q.funct3[1:0]};

	always_comb begin
		case (req_q.funct3)
			f3_sb:   mask = 4'b0001;
			f3_sh:   mask = 4'b0011;
			f3_sw:   mask = 4'b1111;
			default: mask = 4'b0000;
		endcase
	end

	assign ar.addr = addr;
	assign ar.size = size;
	assign aw.addr = addr;
	assign aw.size = size;
	assign w.strb  = {4'b0, mask} << addr[2:0];
	assign w.data  = {32'b0, req_q.src2} << {addr[2:0], 3'b000};

	assign rready = 1'b1;
	assign bready = 1'b1;

	assign done = busy & (req_q.is_store ? (bvalid & bready) : (rvalid & rready));

	always_ff @(posedge clock) begin
		if (accept) begin
			req_q <= req;
		end
	end

	// A valid rises in the cycle after acceptance and holds until its ready is seen.
	always_ff @(posedge clock) begin
		if (rst) begin
			busy    <= 1'b0;
			arvalid <= 1'b0;
			awvalid <= 1'b0;
			wvalid  <= 1'b0;
		end else begin
			if (accept) begin
				busy <= 1'b1;
			end else if (done) begin
				busy <= 1'b0;
			end
			arvalid <= (arvalid & ~arready) | (~arvalid & accept & ~req.is_store);
			awvalid <= (awvalid & ~awready) | (~awvalid & accept & req.is_store);
			wvalid  <= (wvalid & ~wready) | (~wvalid & accept & req.is_store);
		end
	end

	lsu_load_align i_load_align (
		.rdata     (r.data),
		.addr      (addr),
		.funct3    (req_q.funct3),
		.region    (region),
		.load_data (aligned)
	);

	always_ff @(posedge clock) begin
		if (done) begin
			resp.load_data <= req_q.is_store ? 32'b0 : aligned;
			resp.was_store <= req_q.is_store;
		end
	end

	always_ff @(posedge clock) begin
		if (rst) begin
			resp_valid <= 1'b0;
		end else begin
			resp_valid <= done;
		end
	end

endmodule

// ==== hdl/axi_sram.sv ====
`timescale 1ns/1ns

module axi_sram #(
	parameter int mem_addr_bits = 13
) (
	input  logic             clock,
	input  logic             rst,
	input  lsu_pkg::axi_ar_t ar,
	input  logic             arvalid,
	output logic             arready,
	output lsu_pkg::axi_r_t  r,
	output logic             rvalid,
	input  logic             rready,
	input  lsu_pkg::axi_aw_t aw,
	input  logic             awvalid,
	output logic             awready,
	input  lsu_pkg::axi_w_t  w,
	input  logic             wvalid,
	output logic             wready,
	output logic             bvalid,
	input  logic             bready
);

	import lsu_pkg::*;

	localparam int depth = 2 ** (mem_addr_bits - 3);

	logic [63:0]              mem [depth];
	logic [63:0]              rdata_q;
	logic [mem_addr_bits-4:0] rd_idx;
	logic [mem_addr_bits-4:0] wr_idx;
	logic                     idle;
	logic                     rd_fire;
	logic                     wr_fire;

	assign rd_idx = ar.addr[mem_addr_bits-1:3];
	assign wr_idx = aw.addr[mem_addr_bits-1:3];

	// One transaction at a time. A pending response blocks new addresses.
	assign idle    = ~rvalid & ~bvalid;
	assign arready = idle & arvalid;
	assign awready = idle & awvalid & wvalid;
	assign wready  = awready;
	assign rd_fire = arvalid & arready;
	assign wr_fire = awvalid & awready;

	assign r.data = rdata_q;
	assign r.resp = axi_resp_okay;

	// Memory starts cleared so unwritten locations read as zero.
	initial begin
		for (int i = 0; i < depth; i++) begin
			mem[i] = '0;
		end
	end

	always @(posedge clock) begin
		if (wr_fire) begin
			for (int b = 0; b < 8; b++) begin
				if (w.strb[b]) begin
					mem[wr_idx][b*8 +: 8] <= w.data[b*8 +: 8];
				end
			end
		end
		if (rd_fire) begin
			rdata_q <= mem[rd_idx];
		end
	end

	always_ff @(posedge clock) begin
		if (rst) begin
			rvalid <= 1'b0;
			bvalid <= 1'b0;
		end else begin
			if (rd_fire) begin
				rvalid <= 1'b1;
			end else if (rready) begin
				rvalid <= 1'b0;
			end
			if (wr_fire) begin
				bvalid <= 1'b1;
			end else if (bready) begin
				bvalid <= 1'b0;
			end
		end
	end

endmodule

// ==== hdl/lsu_top.sv ====
`timescale 1ns/1ns

module lsu_top #(
	parameter int mem_addr_bits = 13
) (
	input  logic               clock,
	input  logic               rst,
	input  lsu_pkg::lsu_req_t  req,
	input  logic               req_valid,
	output logic               req_ready,
	output lsu_pkg::lsu_resp_t resp,
	output logic               resp_valid,
	input  logic               psel,
	input  logic               penable,
	input  logic               pwrite,
	input  logic [3:0]         paddr,
	input  logic [31:0]        pwdata,
	output logic [31:0]        prdata,
	output logic               pready,
	output logic               pslverr
);

	import lsu_pkg::*;

	lsu_region_t region;
	axi_ar_t     ar;
	axi_r_t      r;
	axi_aw_t     aw;
	axi_w_t      w;
	logic        arvalid;
	logic        arready;
	logic        rvalid;
	logic        rready;
	logic        awvalid;
	logic        awready;
	logic        wvalid;
	logic        wready;
	logic        bvalid;
	logic        bready;

	lsu_region_regs i_region_regs (
		.clock   (clock),
		.rst     (rst),
		.psel    (psel),
		.penable (penable),
		.pwrite  (pwrite),
		.paddr   (paddr),
		.pwdata  (pwdata),
		.prdata  (prdata),
		.pready  (pready),
		.pslverr (pslverr),
		.region  (region)
	);

	lsu_core i_core (
		.clock      (clock),
		.rst        (rst),
		.req        (req),
		.req_valid  (req_valid),
		.req_ready  (req_ready),
		.resp       (resp),
		.resp_valid (resp_valid),
		.region     (region),
		.ar         (ar),
		.arvalid    (arvalid),
		.arready    (arready),
		.r          (r),
		.rvalid     (rvalid),
		.rready     (rready),
		.aw         (aw),
		.awvalid    (awvalid),
		.awready    (awready),
		.w          (w),
		.wvalid     (wvalid),
		.wready     (wready),
		.bvalid     (bvalid),
		.bready     (bready)
	);

	axi_sram #(
		.mem_addr_bits (mem_addr_bits)
	) i_sram (
		.clock   (clock),
		.rst     (rst),
		.ar      (ar),
		.arvalid (arvalid),
		.arready (arready),
		.r       (r),
		.rvalid  (rvalid),
		.rready  (rready),
		.aw      (aw),
		.awvalid (awvalid),
		.awready (awready),
		.w       (w),
		.wvalid  (wvalid),
		.wready  (wready),
		.bvalid  (bvalid),
		.bready  (bready)
	);

endmodule

// ==== test/lsu_checker.sv ====
`timescale 1ns/1ns

module lsu_checker #(
	parameter int mem_addr_bits = 13
) (
	input  logic               clock,
	input  logic               rst,
	input  lsu_pkg::lsu_req_t  req,
	input  logic               req_valid,
	input  logic               req_ready,
	input  lsu_pkg::lsu_resp_t resp,
	input  logic               resp_valid,
	input  logic               psel,
	input  logic               penable,
	input  logic               pwrite,
	input  logic [3:0]         paddr,
	input  logic [31:0]        pwdata,
	input  logic [31:0]        prdata,
	input  logic               pready,
	input  logic               pslverr,
	output int                 data_errors,
	output int                 timing_errors,
	output int                 apb_errors
);

	import lsu_pkg::*;

	localparam int mem_bytes = 2 ** mem_addr_bits;

	logic [7:0]  shadow [mem_bytes];
	lsu_region_t win;
	logic        pending;
	logic        pending_store;
	logic [31:0] expected_data;
	int          cycle;
	int          accept_cycle;
	logic        reset_checked;

	// The memory drops address bits above mem_addr_bits, so the shadow wraps the same way.
	function automatic logic [63:0] shadow_dword(input logic [31:0] addr);
		logic [63:0] dword;
		logic [31:0] base;
		base = addr & (mem_bytes - 8);
		for (int i = 0; i < 8; i++) begin
			dword[i*8 +: 8] = shadow[base + i];
		end
		return dword;
	endfunction

	function automatic logic [31:0] expected_load(input logic [63:0] dword, input logic [31:0] addr,
			input logic [2:0] funct3, input lsu_region_t win_now);
		logic        inside_wide;
		logic        inside_narrow;
		int          offset;
		logic [63:0] lane;
		inside_wide   = (addr >= win_now.wide_base) && (addr < win_now.wide_limit);
		inside_narrow = (addr >= win_now.narrow_base) && (addr < win_now.narrow_limit);
		// Byte position of the value inside the doubleword.
		if (inside_wide) begin
			offset = int'(addr[2:0]);
		end else if (inside_narrow) begin
			offset = int'(addr[1:0]);
		end else begin
			offset = 0;
		end
		lane = dword >> (offset * 8);
		case (funct3)
			f3_lb:   return {{24{lane[7]}}, lane[7:0]};
			f3_lh:   return {{16{lane[15]}}, lane[15:0]};
			f3_lw:   return lane[31:0];
			f3_lbu:  return {24'b0, lane[7:0]};
			f3_lhu:  return {16'b0, lane[15:0]};
			default: return 32'b0;
		endcase
	endfunction

	// Registers sit at offsets 0, 4, 8 and 12 only.
	function automatic logic mapped_offset(input logic [3:0] offset);
		case (offset)
			4'd0, 4'd4, 4'd8, 4'd12: return 1'b1;
			default:                 return 1'b0;
		endcase
	endfunction

	function automatic logic [31:0] window_word(input logic [3:0] offset);
		case (offset[3:2])
			2'd0:    return win.wide_base;
			2'd1:    return win.wide_limit;
			2'd2:    return win.narrow_base;
			default: return win.narrow_limit;
		endcase
	endfunction

	task automatic show_mismatch(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		$display("ERROR at %0t: %s expected %h, got %h", $time, name, expected, actual);
	endtask

	initial begin
		for (int i = 0; i < mem_bytes; i++) begin
			shadow[i] = 8'h00;
		end
		data_errors   = 0;
		timing_errors = 0;
		apb_errors    = 0;
		cycle         = 0;
		accept_cycle  = 0;
		pending       = 1'b0;
		pending_store = 1'b0;
		expected_data = 32'b0;
		reset_checked = 1'b0;
	end

	always @(posedge clock) begin
		logic [31:0] addr;
		int          nbytes;
		int          elapsed;
		cycle++;
		if (rst) begin
			win           = region_reset;
			pending       = 1'b0;
			reset_checked = 1'b0;
		end else begin
			if (!reset_checked) begin
				reset_checked = 1'b1;
				if (!req_ready || resp_valid || pslverr) begin
					$display("Outputs were not idle after reset: req_ready=%b resp_valid=%b pslverr=%b",
						req_ready, resp_valid, pslverr);
					timing_errors++;
				end
			end
			elapsed = cycle - accept_cycle;
			if (resp_valid) begin
				if (!pending) begin
					$display("A response arrived at %0t with no request outstanding.", $time);
					timing_errors++;
				end else begin
					if (elapsed != 3) begin
						show_mismatch("response latency", 32'd3, elapsed);
						timing_errors++;
					end
					if (resp.was_store != pending_store) begin
						show_mismatch("resp.was_store", pending_store, resp.was_store);
						data_errors++;
					end
					if (!pending_store && resp.load_data != expected_data) begin
						show_mismatch("resp.load_data", expected_data, resp.load_data);
						data_errors++;
					end
					pending = 1'b0;
				end
			end else if (pending) begin
				if (elapsed < 3 && req_ready) begin
					$display("req_ready was high at %0t while a request was outstanding.", $time);
					timing_errors++;
				end
				if (elapsed >= 16) begin
					$display("The request accepted in cycle %0d never got a response.", accept_cycle);
					timing_errors++;
					pending = 1'b0;
				end
			end
			if (req_valid && req_ready) begin
				addr          = req.src1 + req.imm;
				pending       = 1'b1;
				pending_store = req.is_store;
				accept_cycle  = cycle;
				if (req.is_store) begin
					nbytes = (req.funct3 == f3_sb) ? 1 : (req.funct3 == f3_sh) ? 2 : 4;
					for (int i = 0; i < nbytes; i++) begin
						shadow[(addr + i) & (mem_bytes - 1)] = req.src2[i*8 +: 8];
					end
				end else begin
					expected_data = expected_load(shadow_dword(addr), addr, req.funct3, win);
				end
			end
			if (psel && penable) begin
				if (pslverr != !mapped_offset(paddr)) begin
					show_mismatch("pslverr", !mapped_offset(paddr), pslverr);
					apb_errors++;
				end
				if (!pready) begin
					$display("pready was low during an APB access at %0t.", $time);
					apb_errors++;
				end
				if (mapped_offset(paddr)) begin
					if (pwrite) begin
						case (paddr[3:2])
							2'd0:    win.wide_base = pwdata;
							2'd1:    win.wide_limit = pwdata;
							2'd2:    win.narrow_base = pwdata;
							default: win.narrow_limit = pwdata;
						endcase
					end else if (prdata != window_word(paddr)) begin
						show_mismatch("prdata", window_word(paddr), prdata);
						apb_errors++;
					end
				end
			end
		end
	end

endmodule

// ==== test/tb_lsu_top.sv ====
`timescale 1ns/1ns

module tb_lsu_top;

	import lsu_pkg::*;

	localparam int mem_addr_bits     = 13;
	localparam int directed_requests = 90;
	localparam int remap_requests    = 6;
	localparam int random_requests   = 200;
	localparam int apb_accesses      = 20;
	localparam int run_cycles        =
		(directed_requests + remap_requests + random_requests) * 10 + apb_accesses * 4 + 100;

	logic        clock;
	logic        rst;
	lsu_req_t    req;
	logic        req_valid;
	logic        req_ready;
	lsu_resp_t   resp;
	logic        resp_valid;
	logic        psel;
	logic        penable;
	logic        pwrite;
	logic [3:0]  paddr;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic        pready;
	logic        pslverr;
	int          data_errors;
	int          timing_errors;
	int          apb_errors;
	int          driver_errors;
	logic [2:0]  store_codes [3] = '{f3_sb, f3_sh, f3_sw};
	logic [2:0]  load_codes [5]  = '{f3_lb, f3_lh, f3_lw, f3_lbu, f3_lhu};

	always #50 clock = ~clock;

	lsu_top #(
		.mem_addr_bits (mem_addr_bits)
	) i_dut (
		.clock      (clock),
		.rst        (rst),
		.req        (req),
		.req_valid  (req_valid),
		.req_ready  (req_ready),
		.resp       (resp),
		.resp_valid (resp_valid),
		.psel       (psel),
		.penable    (penable),
		.pwrite     (pwrite),
		.paddr      (paddr),
		.pwdata     (pwdata),
		.prdata     (prdata),
		.pready     (pready),
		.pslverr    (pslverr)
	);

	lsu_checker #(
		.mem_addr_bits (mem_addr_bits)
	) i_checker (
		.clock         (clock),
		.rst           (rst),
		.req           (req),
		.req_valid     (req_valid),
		.req_ready     (req_ready),
		.resp          (resp),
		.resp_valid    (resp_valid),
		.psel          (psel),
		.penable       (penable),
		.pwrite        (pwrite),
		.paddr         (paddr),
		.pwdata        (pwdata),
		.prdata        (prdata),
		.pready        (pready),
		.pslverr       (pslverr),
		.data_errors   (data_errors),
		.timing_errors (timing_errors),
		.apb_errors    (apb_errors)
	);

	// Every task starts and ends 10 ns after a rising edge.
	task automatic apb_access(input logic write, input logic [3:0] offset, input logic [31:0] data);
		psel    = 1'b1;
		penable = 1'b0;
		pwrite  = write;
		paddr   = offset;
		pwdata  = data;
		@(posedge clock);
		#10;
		penable = 1'b1;
		@(posedge clock);
		#10;
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
	endtask

	// The address is split into a base and a signed 12-bit immediate.
	task automatic send_request(input logic [2:0] funct3, input logic [31:0] addr,
			input logic [31:0] data, input logic is_store);
		logic [31:0] imm;
		int          waited;
		imm    = $urandom_range(0, 4095);
		imm    = {{20{imm[11]}}, imm[11:0]};
		waited = 0;
		while (!req_ready && waited < 20) begin
			@(posedge clock);
			#10;
			waited++;
		end
		if (!req_ready) begin
			$display("The DUT did not become ready for a new request at %0t.", $time);
			driver_errors++;
		end else begin
			req.funct3   = funct3;
			req.src1     = addr - imm;
			req.src2     = data;
			req.imm      = imm;
			req.is_store = is_store;
			req_valid    = 1'b1;
			@(posedge clock);
			#10;
			req_valid = 1'b0;
		end
	endtask

	function automatic logic [31:0] align_addr(input logic [31:0] addr, input logic [2:0] funct3);
		case (funct3[1:0])
			2'd0:    return addr;
			2'd1:    return {addr[31:1], 1'b0};
			default: return {addr[31:2], 2'b00};
		endcase
	endfunction

	// Fills one doubleword with bytes of both signs, then loads it back every possible way.
	task automatic exercise_dword(input logic [31:0] base);
		send_request(f3_sw, base, 32'hf1e2d3c4, 1'b1);
		send_request(f3_sw, base + 4, 32'h85267f98, 1'b1);
		send_request(f3_sh, base + 2, 32'h0000a17e, 1'b1);
		send_request(f3_sb, base + 5, 32'h000000c3, 1'b1);
		for (int i = 0; i < 8; i++) begin
			send_request(f3_lb, base + i, 32'b0, 1'b0);
			send_request(f3_lbu, base + i, 32'b0, 1'b0);
		end
		for (int i = 0; i < 8; i += 2) begin
			send_request(f3_lh, base + i, 32'b0, 1'b0);
			send_request(f3_lhu, base + i, 32'b0, 1'b0);
		end
		for (int i = 0; i < 8; i += 4) begin
			send_request(f3_lw, base + i, 32'b0, 1'b0);
		end
	endtask

	initial begin
		logic [31:0] base;
		int          offset;
		int          pick;
		logic        is_store;
		logic [2:0]  funct3;
		int          total;
		int          waited;
		void'($urandom(11));
		clock         = 1'b0;
		rst           = 1'b1;
		req           = '0;
		req_valid     = 1'b0;
		psel          = 1'b0;
		penable       = 1'b0;
		pwrite        = 1'b0;
		paddr         = 4'h0;
		pwdata        = 32'b0;
		driver_errors = 0;
		repeat (2) @(posedge clock);
		#10;
		rst = 1'b0;

		for (int i = 0; i < 16; i += 4) begin
			apb_access(1'b0, i, 32'b0);
		end
		apb_access(1'b0, 4'd3, 32'b0);
		apb_access(1'b0, 4'd6, 32'b0);
		apb_access(1'b1, 4'd5, 32'hdeadbeef);
		apb_access(1'b0, 4'd4, 32'b0);

		exercise_dword(32'h0f000100);
		exercise_dword(32'h80000200);
		exercise_dword(32'h00000300);

		// Swap the roles of the address ranges.
		apb_access(1'b1, 4'd0, 32'h00000000);
		apb_access(1'b1, 4'd4, 32'h00001000);
		apb_access(1'b1, 4'd8, 32'h0f000000);
		apb_access(1'b1, 4'd12, 32'h0f002000);
		for (int i = 0; i < 16; i += 4) begin
			apb_access(1'b0, i, 32'b0);
		end
		send_request(f3_lw, 32'h00000304, 32'b0, 1'b0);
		send_request(f3_lw, 32'h00000300, 32'b0, 1'b0);
		send_request(f3_lb, 32'h0f000105, 32'b0, 1'b0);
		send_request(f3_lhu, 32'h0f000106, 32'b0, 1'b0);
		send_request(f3_lh, 32'h80000206, 32'b0, 1'b0);
		send_request(f3_lbu, 32'h80000203, 32'b0, 1'b0);
		apb_access(1'b1, 4'd0, wide_base_reset);
		apb_access(1'b1, 4'd4, wide_limit_reset);
		apb_access(1'b1, 4'd8, narrow_base_reset);
		apb_access(1'b1, 4'd12, narrow_limit_reset);

		// All three ranges alias the same low memory, and a few accesses straddle the wide limit.
		for (int n = 0; n < random_requests; n++) begin
			pick = $urandom_range(0, 7);
			if (pick < 3) begin
				base = 32'h0f000000;
			end else if (pick < 5) begin
				base = 32'h80000000;
			end else if (pick < 7) begin
				base = 32'h00000000;
			end else begin
				base = 32'h0f001fc0;
			end
			offset   = (pick == 7) ? $urandom_range(0, 127) : $urandom_range(0, 511);
			is_store = $urandom_range(0, 9) < 4;
			funct3   = is_store ? store_codes[$urandom_range(0, 2)] : load_codes[$urandom_range(0, 4)];
			send_request(funct3, align_addr(base + offset, funct3), $urandom, is_store);
		end

		// Wait for the last response to reach the checker.
		waited = 0;
		while (!resp_valid && waited < 20) begin
			@(posedge clock);
			#10;
			waited++;
		end
		@(posedge clock);
		#10;
		total = data_errors + timing_errors + apb_errors + driver_errors;
		$display("Errors: data %0d, timing %0d, apb %0d, driver %0d",
			data_errors, timing_errors, apb_errors, driver_errors);
		if (total == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

	initial begin
		repeat (run_cycles) @(posedge clock);
		$display("The watchdog expired after %0d cycles before the tests finished.", run_cycles);
		$display("TB FAILED");
		$finish;
	end

endmodule

// ==== compile.f ====
hdl/lsu_pkg.sv
hdl/lsu_region_regs.sv
hdl/lsu_load_align.sv
hdl/lsu_core.sv
hdl/axi_sram.sv
hdl/lsu_top.sv
test/lsu_checker.sv
test/tb_lsu_top.sv

// ==== Bender.yml ====
package:
  name: lsu_subsystem

sources:
  - files:
      - hdl/lsu_pkg.sv
      - hdl/lsu_region_regs.sv
      - hdl/lsu_load_align.sv
      - hdl/lsu_core.sv
      - hdl/axi_sram.sv
      - hdl/lsu_top.sv
  - target: test
    files:
      - test/lsu_checker.sv
      - test/tb_lsu_top.sv
